// File: build.f
common/cdcAccelPkg.sv
source/cdcSync.sv
dualClockFifo/dualClockFifo.sv
source/cmdDecode.sv
source/accumExecute.sv
source/resultPack.sv
source/cdcAccelTop.sv
test/cdcAccel_asserts.sv
test/cdcAccelTb.sv

// File: Makefile
VERILATOR  = verilator
TOP        = cdcAccelTb
FILELIST   = build.f
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -j 0
BUILD_DIR  = obj_dir
RUN_ARGS   = +verilator+error+limit+100
LOG        = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/cdcAccelTb.sv
module cdcAccelTb;

    localparam int WRCLK_PERIOD = 6;
    localparam int RDCLK_PERIOD = 4;
    localparam int DRIVE_DELAY = 1;
    localparam int NUM_RANDOM = 290;      // plus 10 directed commands
    localparam int TIMEOUT_CYCLES = 4000; // 300 commands plus drain

    logic                                    wrclk;
    logic                                    rdclk;
    logic                                    aresetnIn;
    logic                                    cmdValid;
    cdcAccelPkg::opcodeT                     cmdOpcode;
    logic [cdcAccelPkg::DATA_WIDTH-1:0]      cmdOperand;
    logic [cdcAccelPkg::FIFO_DEPTH_LOG2-1:0] cmdLevel;
    logic                                    resultValid;
    logic [cdcAccelPkg::DATA_WIDTH-1:0]      resultValue;
    logic [cdcAccelPkg::TAG_WIDTH-1:0]       resultTag;
    logic                                    resultZero;

    integer seed;
    int     cmdsSent = 0;
    int     resultsSeen = 0;
    int     cycleCount = 0;

    cdcAccelTop uut (
        .wrclk(wrclk),
        .rdclk(rdclk),
        .aresetnIn(aresetnIn),
        .cmdValid(cmdValid),
        .cmdOpcode(cmdOpcode),
        .cmdOperand(cmdOperand),
        .cmdLevel(cmdLevel),
        .resultValid(resultValid),
        .resultValue(resultValue),
        .resultTag(resultTag),
        .resultZero(resultZero)
    );

    bind cdcAccelTop cdcAccel_asserts chk (
        .wrclk(wrclk),
        .aresetnIn(aresetnIn),
        .cmdValid(cmdValid),
        .cmdOpcode(cmdOpcode),
        .cmdOperand(cmdOperand),
        .cmdLevel(cmdLevel),
        .resultValid(resultValid),
        .resultValue(resultValue),
        .resultTag(resultTag),
        .resultZero(resultZero)
    );

    initial begin
        rdclk = 1'b0;
        forever #(RDCLK_PERIOD / 2) rdclk = ~rdclk;
    end

    initial begin
        wrclk = 1'b0;
        forever #(WRCLK_PERIOD / 2) wrclk = ~wrclk;
    end

    // producer backs off while the write side level is above the limit
    task automatic sendCmd(input cdcAccelPkg::opcodeT op, input logic [15:0] value);
        @(posedge wrclk);
        #DRIVE_DELAY;
        while (cmdLevel > cdcAccelPkg::CMD_LEVEL_LIMIT) begin
            cmdValid = 1'b0;
            @(posedge wrclk);
            #DRIVE_DELAY;
        end
        cmdValid = 1'b1;
        cmdOpcode = op;
        cmdOperand = value;
        cmdsSent++;
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge wrclk);
            #DRIVE_DELAY;
            cmdValid = 1'b0;
        end
    endtask

    task automatic sendRandomCmd();
        sendCmd(cdcAccelPkg::opcodeT'(3'($random(seed))), 16'($random(seed)));
    endtask

    always @(posedge rdclk) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("TB FAILED");
            $fatal(1, "timeout, results stopped arriving (%0d of %0d)", resultsSeen, cmdsSent);
        end
    end

    always @(negedge wrclk) begin
        if (resultValid) begin
            resultsSeen++;
        end
    end

    always @(posedge wrclk) begin
        if (uut.chk.failCount != 0) begin
            $display("TB FAILED");
            $fatal(1, "a check in the bound checker failed");
        end
    end

    initial begin
        int gap;
        seed = 32'h82f5;
        aresetnIn = 1'b0;
        cmdValid = 1'b0;
        cmdOpcode = cdcAccelPkg::OP_LOAD;
        cmdOperand = '0;
        repeat (4) @(posedge rdclk);
        @(posedge wrclk);
        #DRIVE_DELAY;
        aresetnIn = 1'b1;
        idleCycles(20);                           // result side has to stay quiet here
        sendCmd(cdcAccelPkg::OP_LOAD, 16'h1234);
        sendCmd(cdcAccelPkg::OP_XOR, 16'h1234);   // zero through xor
        sendCmd(cdcAccelPkg::OP_ADD, 16'hfff0);
        sendCmd(cdcAccelPkg::OP_ADD, 16'h0020);   // wraps past 16 bits
        sendCmd(cdcAccelPkg::OP_SUB, 16'h0030);   // borrows below zero
        sendCmd(cdcAccelPkg::OP_OR, 16'h0f0f);
        sendCmd(cdcAccelPkg::OP_AND, 16'h00ff);
        sendCmd(cdcAccelPkg::OP_HOLD, 16'hbeef);
        sendCmd(cdcAccelPkg::OP_CLEAR, 16'hffff);
        sendCmd(cdcAccelPkg::OP_HOLD, 16'h0000);  // reports the cleared zero again
        idleCycles(10);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            sendRandomCmd();
            if ((i % 60) >= 30) begin             // back-to-back bursts in between
                gap = $random(seed) & 3;
                if (gap != 0) begin
                    idleCycles(gap);
                end
            end
        end
        idleCycles(1);
        wait (resultsSeen == cmdsSent);
        idleCycles(20);
        if (resultsSeen == cmdsSent && uut.chk.failCount == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("TB FAILED");
            $fatal(1, "%0d results came back for %0d commands", resultsSeen, cmdsSent);
        end
    end

endmodule

// File: test/cdcAccel_asserts.sv
module cdcAccel_asserts (
    input logic                                     wrclk,
    input logic                                     aresetnIn,
    input logic                                     cmdValid,
    input cdcAccelPkg::opcodeT                      cmdOpcode,
    input logic [cdcAccelPkg::DATA_WIDTH-1:0]       cmdOperand,
    input logic [cdcAccelPkg::FIFO_DEPTH_LOG2-1:0]  cmdLevel,
    input logic                                     resultValid,
    input logic [cdcAccelPkg::DATA_WIDTH-1:0]       resultValue,
    input logic [cdcAccelPkg::TAG_WIDTH-1:0]        resultTag,
    input logic                                     resultZero
);

    logic [cdcAccelPkg::DATA_WIDTH-1:0] refAcc;
    logic [cdcAccelPkg::DATA_WIDTH-1:0] nextAcc;
    logic [cdcAccelPkg::DATA_WIDTH-1:0] expValue [1 << cdcAccelPkg::TAG_WIDTH];
    logic [cdcAccelPkg::TAG_WIDTH-1:0]  pushIdx;    // also the tag the next command should get
    logic [cdcAccelPkg::TAG_WIDTH-1:0]  popIdx;
    logic                               resultSeen; // result caught mid-cycle, popped at next posedge
    logic                               seenCmd;
    int                                 failCount = 0;

    always_comb begin
        case (cmdOpcode)
            cdcAccelPkg::OP_LOAD:  nextAcc = cmdOperand;
            cdcAccelPkg::OP_ADD:   nextAcc = refAcc + cmdOperand; // wraps at 16 bits
            cdcAccelPkg::OP_SUB:   nextAcc = refAcc - cmdOperand;
            cdcAccelPkg::OP_AND:   nextAcc = refAcc & cmdOperand;
            cdcAccelPkg::OP_OR:    nextAcc = refAcc | cmdOperand;
            cdcAccelPkg::OP_XOR:   nextAcc = refAcc ^ cmdOperand;
            cdcAccelPkg::OP_CLEAR: nextAcc = '0;
            default:               nextAcc = refAcc;          // hold
        endcase
    end

    always_ff @(posedge wrclk or negedge aresetnIn) begin
        if (!aresetnIn) begin
            refAcc <= '0;
            pushIdx <= '0;
            popIdx <= '0;
            seenCmd <= 1'b0;
        end else begin
            if (cmdValid) begin
                refAcc <= nextAcc;
                pushIdx <= pushIdx + 1'b1;
                seenCmd <= 1'b1;
            end
            if (resultSeen) begin
                popIdx <= popIdx + 1'b1;
            end
        end
    end

    always_ff @(posedge wrclk) begin
        if (cmdValid) begin
            expValue[pushIdx] <= nextAcc;
        end
    end

    always_ff @(negedge wrclk or negedge aresetnIn) begin
        if (!aresetnIn) begin
            resultSeen <= 1'b0;
        end else begin
            resultSeen <= resultValid;
        end
    end

    // checks run mid-cycle, where every port is stable
    valueMatch: assert property (@(negedge wrclk) disable iff (!aresetnIn)
        resultValid |-> resultValue == expValue[popIdx])
        else begin
            failCount++;
            $error("FAIL %0t: result value %h, expected %h", $time, resultValue, expValue[popIdx]);
        end

    tagMatch: assert property (@(negedge wrclk) disable iff (!aresetnIn)
        resultValid |-> resultTag == popIdx)
        else begin
            failCount++;
            $error("FAIL %0t: result tag %0d, expected %0d", $time, resultTag, popIdx);
        end

    zeroFlag: assert property (@(negedge wrclk) disable iff (!aresetnIn)
        resultValid |-> resultZero == (resultValue == '0))
        else begin
            failCount++;
            $error("FAIL %0t: zero flag %b for value %h", $time, resultZero, resultValue);
        end

    noOrphan: assert property (@(negedge wrclk) disable iff (!aresetnIn)
        resultValid |-> popIdx != pushIdx)
        else begin
            failCount++;
            $error("a result arrived with no command outstanding at %0t", $time);
        end

    quietAfterReset: assert property (@(negedge wrclk) disable iff (!aresetnIn)
        !seenCmd |-> !resultValid)
        else begin
            failCount++;
            $error("a result appeared before any command was written at %0t", $time);
        end

    levelRule: assert property (@(negedge wrclk) disable iff (!aresetnIn)
        cmdValid |-> cmdLevel <= cdcAccelPkg::CMD_LEVEL_LIMIT)
        else begin
            failCount++;
            $error("a command was written above the fill limit, level %0d at %0t", cmdLevel, $time);
        end

endmodule

// File: source/cdcAccelTop.sv
module cdcAccelTop (
    input  logic                                     wrclk,
    input  logic                                     rdclk,
    input  logic                                     aresetnIn,

    input  logic                                     cmdValid,
    input  cdcAccelPkg::opcodeT                      cmdOpcode,
    input  logic [cdcAccelPkg::DATA_WIDTH-1:0]       cmdOperand,
    output logic [cdcAccelPkg::FIFO_DEPTH_LOG2-1:0]  cmdLevel,

    output logic                                     resultValid,
    output logic [cdcAccelPkg::DATA_WIDTH-1:0]       resultValue,
    output logic [cdcAccelPkg::TAG_WIDTH-1:0]        resultTag,
    output logic                                     resultZero
);

    logic wrResetn;
    logic rdResetn;

    cdcAccelPkg::cmdT cmdWord;
    cdcAccelPkg::cmdT cmdPopWord;
    logic cmdPopValid;

    logic opValid;
    cdcAccelPkg::opcodeT opSelect;
    logic [cdcAccelPkg::DATA_WIDTH-1:0] operand;
    logic writesAcc;

    logic accValid;
    logic [cdcAccelPkg::DATA_WIDTH-1:0] accValue;

    logic resValid;
    cdcAccelPkg::resultT resWord;
    cdcAccelPkg::resultT resultWord;

    resetSynchronizer #(.SYNC_STAGES(cdcAccelPkg::SYNC_STAGES)) wrResetSync (
        .clk(wrclk),
        .aresetnIn(aresetnIn),
        .resetnOut(wrResetn)
    );

    resetSynchronizer #(.SYNC_STAGES(cdcAccelPkg::SYNC_STAGES)) rdResetSync (
        .clk(rdclk),
        .aresetnIn(aresetnIn),
        .resetnOut(rdResetn)
    );

    assign cmdWord.opcode = cmdOpcode;
    assign cmdWord.operand = cmdOperand;

    dualClockFifo #(
        .payloadT(cdcAccelPkg::cmdT),
        .DEPTH_LOG2(cdcAccelPkg::FIFO_DEPTH_LOG2),
        .SYNC_STAGES(cdcAccelPkg::SYNC_STAGES)
    ) cmdFifo (
        .wrclk(wrclk),
        .writeEnable(cmdValid),
        .dataIn(cmdWord),
        .wrusedw(cmdLevel),
        .rdclk(rdclk),
        .rdclr(!rdResetn),
        .dataOutValid(cmdPopValid),
        .dataOut(cmdPopWord)
    );

    cmdDecode decode (
        .rdclk(rdclk),
        .resetn(rdResetn),
        .inValid(cmdPopValid),
        .cmdIn(cmdPopWord),
        .opValid(opValid),
        .opSelect(opSelect),
        .operand(operand),
        .writesAcc(writesAcc)
    );

    accumExecute execute (
        .rdclk(rdclk),
        .resetn(rdResetn),
        .opValid(opValid),
        .opSelect(opSelect),
        .operand(operand),
        .writesAcc(writesAcc),
        .accValid(accValid),
        .accValue(accValue)
    );

    resultPack pack (
        .rdclk(rdclk),
        .resetn(rdResetn),
        .accValid(accValid),
        .accValue(accValue),
        .resValid(resValid),
        .resOut(resWord)
    );

    // clocks swap roles on the return path
    dualClockFifo #(
        .payloadT(cdcAccelPkg::resultT),
        .DEPTH_LOG2(cdcAccelPkg::FIFO_DEPTH_LOG2),
        .SYNC_STAGES(cdcAccelPkg::SYNC_STAGES)
    ) resultFifo (
        .wrclk(rdclk),
        .writeEnable(resValid),
        .dataIn(resWord),
        .wrusedw(),           // drained every cycle, level not needed
        .rdclk(wrclk),
        .rdclr(!wrResetn),
        .dataOutValid(resultValid),
        .dataOut(resultWord)
    );

    assign resultValue = resultWord.value;
    assign resultTag = resultWord.tag;
    assign resultZero = resultWord.zero;

endmodule

// File: source/resultPack.sv
module resultPack (
    input  logic                                rdclk,
    input  logic                                resetn,

    input  logic                                accValid,
    input  logic [cdcAccelPkg::DATA_WIDTH-1:0]  accValue,

    output logic                                resValid,
    output cdcAccelPkg::resultT                 resOut
);

    logic [cdcAccelPkg::TAG_WIDTH-1:0] tagCount; // wraps at 256
    logic                              isZero;

    assign isZero = (accValue == '0);

    always_ff @(posedge rdclk or negedge resetn) begin
        if (!resetn) begin
            tagCount <= '0;
            resValid <= 1'b0;
        end else begin
            resValid <= accValid;
            if (accValid) begin
                tagCount <= tagCount + 1'b1;
            end
        end
    end

    // first result after reset carries tag 0
    always_ff @(posedge rdclk) begin
        if (accValid) begin
            resOut.tag <= tagCount;
            resOut.value <= accValue;
            resOut.zero <= isZero;
        end
    end

endmodule

// File: source/accumExecute.sv
module accumExecute (
    input  logic                                rdclk,
    input  logic                                resetn,

    input  logic                                opValid,
    input  cdcAccelPkg::opcodeT                 opSelect,
    input  logic [cdcAccelPkg::DATA_WIDTH-1:0]  operand,
    input  logic                                writesAcc,

    output logic                                accValid,
    output logic [cdcAccelPkg::DATA_WIDTH-1:0]  accValue
);

    logic [cdcAccelPkg::DATA_WIDTH-1:0] accReg;
    logic [cdcAccelPkg::DATA_WIDTH-1:0] nextAcc;

    // add and sub wrap modulo 2^16
    always_comb begin
        unique case (opSelect)
            cdcAccelPkg::OP_LOAD: begin
                nextAcc = operand;
            end
            cdcAccelPkg::OP_ADD: begin
                nextAcc = accReg + operand;
            end
            cdcAccelPkg::OP_SUB: begin
                nextAcc = accReg - operand;
            end
            cdcAccelPkg::OP_AND: begin
                nextAcc = accReg & operand;
            end
            cdcAccelPkg::OP_OR: begin
                nextAcc = accReg | operand;
            end
            cdcAccelPkg::OP_XOR: begin
                nextAcc = accReg ^ operand;
            end
            cdcAccelPkg::OP_CLEAR: begin
                nextAcc = '0;
            end
            cdcAccelPkg::OP_HOLD: begin
                nextAcc = accReg;
            end
        endcase
    end

    always_ff @(posedge rdclk or negedge resetn) begin
        if (!resetn) begin
            accReg <= '0;
            accValid <= 1'b0;
        end else begin
            accValid <= opValid; // value below is already post-op when this rises
            if (opValid && writesAcc) begin
                accReg <= nextAcc;
            end
        end
    end

    assign accValue = accReg;

endmodule

// File: source/cmdDecode.sv
module cmdDecode (
    input  logic                                rdclk,
    input  logic                                resetn,

    input  logic                                inValid,
    input  cdcAccelPkg::cmdT                    cmdIn,

    output logic                                opValid,
    output cdcAccelPkg::opcodeT                 opSelect,
    output logic [cdcAccelPkg::DATA_WIDTH-1:0]  operand,
    output logic                                writesAcc
);

    logic holdOp;

    assign holdOp = (cmdIn.opcode == cdcAccelPkg::OP_HOLD);

    always_ff @(posedge rdclk or negedge resetn) begin
        if (!resetn) begin
            opValid <= 1'b0;
        end else begin
            opValid <= inValid;
        end
    end

    // fields only change with a new command
    always_ff @(posedge rdclk) begin
        if (inValid) begin
            opSelect <= cmdIn.opcode;
            operand <= cmdIn.operand;
            writesAcc <= !holdOp; // hold reports acc without touching it
        end
    end

endmodule

// File: dualClockFifo/dualClockFifo.sv
// Behavioral dual-clock FIFO. The read side pops on its own whenever data
// is present and presents the word with a one-cycle dataOutValid strobe.
// One slot stays unused so that full and empty can be told apart.
module dualClockFifo #(
    parameter type payloadT = logic [7:0],
    parameter int  DEPTH_LOG2 = 4,
    parameter int  SYNC_STAGES = 3
) (
    input  logic                  wrclk,
    input  logic                  writeEnable,
    input  payloadT               dataIn,
    output logic [DEPTH_LOG2-1:0] wrusedw,

    input  logic                  rdclk,
    input  logic                  rdclr,      // active high, clears both heads
    output logic                  dataOutValid,
    output payloadT               dataOut
);

    function automatic logic [DEPTH_LOG2-1:0] grayToBin(input logic [DEPTH_LOG2-1:0] gray);
        logic [DEPTH_LOG2-1:0] bin;
        bin[DEPTH_LOG2-1] = gray[DEPTH_LOG2-1];
        for (int i = DEPTH_LOG2 - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

    payloadT memory [1 << DEPTH_LOG2];

    logic [DEPTH_LOG2-1:0] writeHead;
    logic [DEPTH_LOG2-1:0] writeGray;
    logic [DEPTH_LOG2-1:0] writeGraySyncToRead;

    logic [DEPTH_LOG2-1:0] readHead;
    logic [DEPTH_LOG2-1:0] readGray;
    logic [DEPTH_LOG2-1:0] readGraySyncToWrite;

    logic rdEmpty;

    assign writeGray = writeHead ^ (writeHead >> 1);
    assign readGray = readHead ^ (readHead >> 1);

    synchronizer #(
        .WIDTH(DEPTH_LOG2),
        .SYNC_STAGES(SYNC_STAGES)
    ) writeSyncPipe (
        .inClk(wrclk),
        .dataIn(writeGray),
        .outClk(rdclk),
        .dataOut(writeGraySyncToRead)
    );

    synchronizer #(
        .WIDTH(DEPTH_LOG2),
        .SYNC_STAGES(SYNC_STAGES)
    ) readSyncPipe (
        .inClk(rdclk),
        .dataIn(readGray),
        .outClk(wrclk),
        .dataOut(readGraySyncToWrite)
    );

    // write side view, lags the reader so it can only overstate the level
    assign wrusedw = writeHead - grayToBin(readGraySyncToWrite);

    // equal Gray codes mean equal heads
    assign rdEmpty = (writeGraySyncToRead == readGray);

    always_ff @(posedge wrclk or posedge rdclr) begin
        if (rdclr) begin
            writeHead <= '0;
        end else if (writeEnable) begin
            writeHead <= writeHead + 1'b1; // wraps with the address width
        end
    end

    always_ff @(posedge wrclk) begin
        if (writeEnable) begin
            memory[writeHead] <= dataIn;
        end
    end

    always_ff @(posedge rdclk or posedge rdclr) begin
        if (rdclr) begin
            readHead <= '0;
            dataOutValid <= 1'b0;
        end else begin
            dataOutValid <= !rdEmpty;
            if (!rdEmpty) begin
                readHead <= readHead + 1'b1;
            end
        end
    end

    always_ff @(posedge rdclk) begin
        if (!rdEmpty) begin
            dataOut <= memory[readHead];
        end
    end

endmodule

// File: source/cdcSync.sv
// Multi-bit data is only safe here when at most one bit changes per
// source clock, as with the Gray coded FIFO pointers.
module synchronizer #(
    parameter int WIDTH = 1,
    parameter int SYNC_STAGES = 3
) (
    input  logic             inClk,
    input  logic [WIDTH-1:0] dataIn,

    input  logic             outClk,
    output logic [WIDTH-1:0] dataOut
);

    logic [WIDTH-1:0] inReg;                        // launch flop, hides source glitches
    logic [SYNC_STAGES-1:0][WIDTH-1:0] syncChain;

    always_ff @(posedge inClk) begin
        inReg <= dataIn;
    end

    always_ff @(posedge outClk) begin
        syncChain <= {syncChain[SYNC_STAGES-2:0], inReg};
    end

    assign dataOut = syncChain[SYNC_STAGES-1];

endmodule


module resetSynchronizer #(
    parameter int SYNC_STAGES = 3
) (
    input  logic clk,
    input  logic aresetnIn,  // async, may drop at any time
    output logic resetnOut
);

    logic [SYNC_STAGES-1:0] rstLine;

    // assert immediately, release after SYNC_STAGES clean edges
    always_ff @(posedge clk or negedge aresetnIn) begin
        if (!aresetnIn) begin
            rstLine <= '0;
        end else begin
            rstLine <= {rstLine[SYNC_STAGES-2:0], 1'b1};
        end
    end

    assign resetnOut = rstLine[SYNC_STAGES-1];

endmodule

// File: common/cdcAccelPkg.sv
package cdcAccelPkg;

    localparam int DATA_WIDTH = 16;      // accumulator and operand width
    localparam int TAG_WIDTH = 8;        // result sequence tag
    localparam int FIFO_DEPTH_LOG2 = 4;  // address width of both FIFOs
    localparam int SYNC_STAGES = 3;      // pointer and reset synchronizer depth
    localparam int CMD_LEVEL_LIMIT = 12; // last cmd fill level that still takes a write

    // every 3-bit code is defined, so decode never sees an unknown opcode
    typedef enum logic [2:0] {
        OP_LOAD  = 3'd0, // acc = operand
        OP_ADD   = 3'd1,
        OP_SUB   = 3'd2,
        OP_AND   = 3'd3,
        OP_OR    = 3'd4,
        OP_XOR   = 3'd5,
        OP_CLEAR = 3'd6, // acc = 0
        OP_HOLD  = 3'd7  // acc unchanged, still reported
    } opcodeT;

    // 19 bits
    typedef struct packed {
        opcodeT                opcode;
        logic [DATA_WIDTH-1:0] operand;
    } cmdT;

    // 25 bits
    typedef struct packed {
        logic [TAG_WIDTH-1:0]  tag;
        logic [DATA_WIDTH-1:0] value;
        logic                  zero;
    } resultT;

endpackage
